/* bench/dw_downsizer_sva.sv */
// --------------------
// Stability assertions for the downsizer channels.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module dw_downsizer_sva (
  input wire logic               clk_i,
  input wire logic               rst_n_i,
  input wire logic               mst_aw_valid_o,
  input wire logic               mst_aw_ready_i,
  input wire dw_pkg::addr_chan_t mst_aw_o,
  input wire logic               mst_w_valid_o,
  input wire logic               mst_w_ready_i,
  input wire dw_pkg::mst_w_t     mst_w_o,
  input wire logic               mst_ar_valid_o,
  input wire logic               mst_ar_ready_i,
  input wire dw_pkg::addr_chan_t mst_ar_o,
  input wire logic               slv_b_valid_o,
  input wire logic               slv_b_ready_i,
  input wire dw_pkg::b_t         slv_b_o,
  input wire logic               slv_r_valid_o,
  input wire logic               slv_r_ready_i,
  input wire dw_pkg::slv_r_t     slv_r_o
);

  // A stalled beat keeps its valid and its payload until it is taken.
  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_aw_valid_o && !mst_aw_ready_i) |=> (mst_aw_valid_o && $stable(mst_aw_o)))
    else $error("Master AW changed while stalled");

  w_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_w_valid_o && !mst_w_ready_i) |=> (mst_w_valid_o && $stable(mst_w_o)))
    else $error("Master W changed while stalled");

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=> (mst_ar_valid_o && $stable(mst_ar_o)))
    else $error("Master AR changed while stalled");

  // Slave responses hold only because the master side holds the last beat.
  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_b_valid_o && !slv_b_ready_i) |=> (slv_b_valid_o && $stable(slv_b_o)))
    else $error("Slave B changed while stalled");

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_r_valid_o && !slv_r_ready_i) |=> (slv_r_valid_o && $stable(slv_r_o)))
    else $error("Slave R changed while stalled");

endmodule

bind axi_lite_dw_downsizer dw_downsizer_sva sva_i (
  .clk_i          ( clk_i          ),
  .rst_n_i        ( rst_n_i        ),
  .mst_aw_valid_o ( mst_aw_valid_o ),
  .mst_aw_ready_i ( mst_aw_ready_i ),
  .mst_aw_o       ( mst_aw_o       ),
  .mst_w_valid_o  ( mst_w_valid_o  ),
  .mst_w_ready_i  ( mst_w_ready_i  ),
  .mst_w_o        ( mst_w_o        ),
  .mst_ar_valid_o ( mst_ar_valid_o ),
  .mst_ar_ready_i ( mst_ar_ready_i ),
  .mst_ar_o       ( mst_ar_o       ),
  .slv_b_valid_o  ( slv_b_valid_o  ),
  .slv_b_ready_i  ( slv_b_ready_i  ),
  .slv_b_o        ( slv_b_o        ),
  .slv_r_valid_o  ( slv_r_valid_o  ),
  .slv_r_ready_i  ( slv_r_ready_i  ),
  .slv_r_o        ( slv_r_o        )
);

`default_nettype wire

/* bench/tb_dw_downsizer.sv */
// --------------------
// Testbench of the AXI4-Lite downsizer.
// Random wide traffic against a narrow memory responder and a byte model.
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "dw_defines.svh"

module tb_dw_downsizer;

  import dw_pkg::*;

  localparam int FACTOR    = `DW_DOWNSIZE_FACTOR;
  localparam int MST_WIDTH = `DW_MST_DATA_WIDTH;
  localparam int MST_BYTES = `DW_MST_STRB_WIDTH;
  localparam int SLV_BYTES = `DW_SLV_STRB_WIDTH;
  localparam int NUM_TXN   = 300;
  localparam int TIMEOUT   = 200;

  // DUT signals carry the names of the ports they connect to.
  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       slv_aw_valid_i, slv_aw_ready_o, slv_w_valid_i, slv_w_ready_o;
  logic       slv_b_valid_o, slv_b_ready_i, slv_ar_valid_i, slv_ar_ready_o;
  logic       slv_r_valid_o, slv_r_ready_i;
  addr_chan_t slv_aw_i, slv_ar_i, mst_aw_o, mst_ar_o;
  slv_w_t     slv_w_i;
  b_t         slv_b_o, mst_b_i;
  slv_r_t     slv_r_o;
  logic       mst_aw_valid_o, mst_aw_ready_i, mst_w_valid_o, mst_w_ready_i;
  logic       mst_b_valid_i, mst_b_ready_o, mst_ar_valid_o, mst_ar_ready_i;
  logic       mst_r_valid_i, mst_r_ready_o;
  mst_w_t     mst_w_o;
  mst_r_t     mst_r_i;

  // Memory behind the master port, and the byte model of the slave view.
  logic [7:0]  mst_mem [0:63];
  logic [7:0]  model_mem [0:63];
  logic [31:0] lfsr_q;
  int          check_count;
  int          error_count;
  logic        timed_out;

  axi_lite_dw_downsizer dut_i (.*);

  always #20 clk_i = ~clk_i;

  // Right-shifting Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // The LFSR steps once per bit taken and the newest bit lands at the bottom.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic logic rand_bit();
    logic [63:0] v;
    v = rand_bits(1);
    return v[0];
  endfunction

  // About one beat in four gets a random, possibly non-OKAY response.
  function automatic resp_t rand_resp();
    logic [63:0] v;
    v = rand_bits(2);
    if (v[1:0] != 2'b00) begin
      return RESP_OKAY;
    end
    v = rand_bits(2);
    return v[1:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
    end
  endtask

  task automatic check_idle_valids();
    check_value("mst_aw_valid_o", 64'(1'b0), 64'(mst_aw_valid_o));
    check_value("mst_w_valid_o", 64'(1'b0), 64'(mst_w_valid_o));
    check_value("mst_ar_valid_o", 64'(1'b0), 64'(mst_ar_valid_o));
    check_value("slv_b_valid_o", 64'(1'b0), 64'(slv_b_valid_o));
    check_value("slv_r_valid_o", 64'(1'b0), 64'(slv_r_valid_o));
  endtask

  // The responder commits the enabled bytes of one narrow write.
  task automatic store_lane(input addr_chan_t aw, input mst_w_t w);
    int         j;
    logic [5:0] idx;
    for (j = 0; j < MST_BYTES; j++) begin
      idx = {aw.addr[5:2], j[1:0]};
      if (w.strb[j]) begin
        mst_mem[idx] = w.data[8*j +: 8];
      end
    end
  endtask

  function automatic logic [31:0] load_lane(input logic [31:0] addr);
    logic [31:0] d;
    int          j;
    for (j = 0; j < MST_BYTES; j++) begin
      d[8*j +: 8] = mst_mem[{addr[5:2], j[1:0]}];
    end
    return d;
  endfunction

  function automatic logic [31:0] lane_addr(input logic [31:0] addr, input int k);
    return (addr & ~32'(SLV_BYTES - 1)) + 32'(k * MST_BYTES);
  endfunction

  // Runs one wide write while the responder answers each narrow beat.
  task automatic run_write(input logic [31:0] addr, input logic [2:0] prot,
                           input logic [63:0] data, input logic [7:0] strb);
    addr_chan_t aw_lane [FACTOR];
    mst_w_t     w_lane [FACTOR];
    int         aw_cnt, w_cnt, b_cnt, cycles, i;
    logic       aw_done, w_done, b_pend, b_seen;
    resp_t      b_resp, exp_resp;
    logic [5:0] idx;
    aw_cnt = 0;
    w_cnt = 0;
    b_cnt = 0;
    cycles = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    b_pend = 1'b0;
    b_seen = 1'b0;
    b_resp = RESP_OKAY;
    exp_resp = RESP_OKAY;
    for (i = 0; i < SLV_BYTES; i++) begin
      idx = {addr[5:3], i[2:0]};
      if (strb[i]) begin
        model_mem[idx] = data[8*i +: 8];
      end
    end
    while (!b_seen && cycles < TIMEOUT) begin
      @(negedge clk_i);
      slv_aw_i.addr = addr;
      slv_aw_i.prot = prot;
      slv_w_i.data = data;
      slv_w_i.strb = strb;
      slv_aw_valid_i = !aw_done;
      slv_w_valid_i = !w_done;
      // The read response channel stays idle during a write.
      mst_r_valid_i = 1'b0;
      mst_aw_ready_i = rand_bit();
      mst_w_ready_i = rand_bit();
      slv_b_ready_i = rand_bit();
      // A B beat is offered once its lane has both address and data.
      if (!b_pend && b_cnt < aw_cnt && b_cnt < w_cnt) begin
        b_pend = 1'b1;
        b_resp = rand_resp();
        store_lane(aw_lane[b_cnt], w_lane[b_cnt]);
      end
      mst_b_valid_i = b_pend;
      mst_b_i.resp = b_resp;
      @(posedge clk_i);
      if (slv_aw_valid_i && slv_aw_ready_o) aw_done = 1'b1;
      if (slv_w_valid_i && slv_w_ready_o) w_done = 1'b1;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (aw_cnt < FACTOR) begin
          check_value("mst_aw_o.addr", 64'(lane_addr(addr, aw_cnt)), 64'(mst_aw_o.addr));
          check_value("mst_aw_o.prot", 64'(prot), 64'(mst_aw_o.prot));
          aw_lane[aw_cnt] = mst_aw_o;
          aw_cnt++;
        end else begin
          error_count++;
          $display("A write produced more master AW beats than lanes");
        end
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (w_cnt < FACTOR) begin
          check_value("mst_w_o.data", 64'(data[w_cnt*MST_WIDTH +: MST_WIDTH]),
                      64'(mst_w_o.data));
          check_value("mst_w_o.strb", 64'(strb[w_cnt*MST_BYTES +: MST_BYTES]),
                      64'(mst_w_o.strb));
          w_lane[w_cnt] = mst_w_o;
          w_cnt++;
        end else begin
          error_count++;
          $display("A write produced more master W beats than lanes");
        end
      end
      // The master B is taken first, so the merged value includes the last beat.
      if (mst_b_valid_i && mst_b_ready_o) begin
        exp_resp = exp_resp | b_resp;
        b_cnt++;
        b_pend = 1'b0;
      end
      if (slv_b_valid_o && slv_b_ready_i) begin
        check_value("slv_b_o.resp", 64'(exp_resp), 64'(slv_b_o.resp));
        check_value("master B count", 64'(FACTOR), 64'(b_cnt));
        b_seen = 1'b1;
      end
      check_value("slv_r_valid_o", 64'(1'b0), 64'(slv_r_valid_o));
      cycles++;
    end
    if (!b_seen) begin
      error_count++;
      timed_out = 1'b1;
      $display("Timeout: write to 0x%0h got no slave B in %0d cycles", addr, TIMEOUT);
    end
  endtask

  // Runs one wide read that is gathered from narrow beats of the responder memory.
  task automatic run_read(input logic [31:0] addr, input logic [2:0] prot);
    addr_chan_t  ar_lane [FACTOR];
    mst_r_t      r_beat;
    int          ar_cnt, r_cnt, cycles, i;
    logic        ar_done, r_pend, r_seen;
    resp_t       exp_resp;
    logic [63:0] exp_data;
    ar_cnt = 0;
    r_cnt = 0;
    cycles = 0;
    ar_done = 1'b0;
    r_pend = 1'b0;
    r_seen = 1'b0;
    exp_resp = RESP_OKAY;
    r_beat = '0;
    for (i = 0; i < SLV_BYTES; i++) begin
      exp_data[8*i +: 8] = model_mem[{addr[5:3], i[2:0]}];
    end
    while (!r_seen && cycles < TIMEOUT) begin
      @(negedge clk_i);
      slv_ar_i.addr = addr;
      slv_ar_i.prot = prot;
      slv_ar_valid_i = !ar_done;
      // The write response channel stays idle during a read.
      mst_b_valid_i = 1'b0;
      mst_ar_ready_i = rand_bit();
      slv_r_ready_i = rand_bit();
      if (!r_pend && r_cnt < ar_cnt) begin
        r_pend = 1'b1;
        r_beat.data = load_lane(ar_lane[r_cnt].addr);
        r_beat.resp = rand_resp();
      end
      mst_r_valid_i = r_pend;
      mst_r_i = r_beat;
      @(posedge clk_i);
      if (slv_ar_valid_i && slv_ar_ready_o) ar_done = 1'b1;
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (ar_cnt < FACTOR) begin
          check_value("mst_ar_o.addr", 64'(lane_addr(addr, ar_cnt)), 64'(mst_ar_o.addr));
          check_value("mst_ar_o.prot", 64'(prot), 64'(mst_ar_o.prot));
          ar_lane[ar_cnt] = mst_ar_o;
          ar_cnt++;
        end else begin
          error_count++;
          $display("A read produced more master AR beats than lanes");
        end
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        exp_resp = exp_resp | r_beat.resp;
        r_cnt++;
        r_pend = 1'b0;
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        check_value("slv_r_o.data", exp_data, slv_r_o.data);
        check_value("slv_r_o.resp", 64'(exp_resp), 64'(slv_r_o.resp));
        check_value("master R count", 64'(FACTOR), 64'(r_cnt));
        r_seen = 1'b1;
      end
      check_value("slv_b_valid_o", 64'(1'b0), 64'(slv_b_valid_o));
      cycles++;
    end
    if (!r_seen) begin
      error_count++;
      timed_out = 1'b1;
      $display("Timeout: read of 0x%0h got no slave R in %0d cycles", addr, TIMEOUT);
    end
  endtask

  initial begin
    int          t;
    logic [63:0] r;
    logic [31:0] addr;
    logic [2:0]  prot;
    logic [63:0] data;
    logic [7:0]  strb;
    rst_n_i = 1'b0;
    {slv_aw_valid_i, slv_w_valid_i, slv_b_ready_i, slv_ar_valid_i, slv_r_ready_i} = '0;
    {mst_aw_ready_i, mst_w_ready_i, mst_b_valid_i, mst_ar_ready_i, mst_r_valid_i} = '0;
    slv_aw_i = '0;
    slv_w_i = '0;
    slv_ar_i = '0;
    mst_b_i = '0;
    mst_r_i = '0;
    lfsr_q = 32'd16;
    check_count = 0;
    error_count = 0;
    timed_out = 1'b0;
    // Both memories start from the same address-dependent pattern.
    for (t = 0; t < 64; t++) begin
      mst_mem[t] = 8'(t * 37 + 11);
      model_mem[t] = 8'(t * 37 + 11);
    end
    // Each falling edge follows a rising edge that has seen the reset.
    repeat (16) begin
      @(negedge clk_i);
      check_idle_valids();
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle_valids();
    for (t = 0; t < NUM_TXN && !timed_out; t++) begin
      r = rand_bits(6);
      addr = 32'h4000_0000 | {26'd0, r[5:0]};
      r = rand_bits(3);
      prot = r[2:0];
      if (rand_bit()) begin
        data = rand_bits(64);
        r = rand_bits(8);
        strb = r[7:0];
        run_write(addr, prot, data, strb);
      end else begin
        run_read(addr, prot);
      end
    end
    @(negedge clk_i);
    {slv_aw_valid_i, slv_w_valid_i, slv_ar_valid_i, mst_b_valid_i, mst_r_valid_i} = '0;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* common/dw_defines.svh */
// --------------------
// AXI4-Lite downsizer width and ratio macros.
// Slave port is 64 bits wide, master port is 32 bits wide.
// --------------------

`ifndef DW_DEFINES_SVH
`define DW_DEFINES_SVH

// Address width shared by both ports.
`define DW_ADDR_WIDTH 32

// Data widths of the wide slave port and the narrow master port.
`define DW_SLV_DATA_WIDTH 64
`define DW_MST_DATA_WIDTH 32

// Byte strobe widths, one bit per data byte.
`define DW_SLV_STRB_WIDTH 8
`define DW_MST_STRB_WIDTH 4

// Number of master beats per slave beat, a power of two.
`define DW_DOWNSIZE_FACTOR 2

// The lane selector is log2 of the factor wide.
// It sits in the address right above the master byte offset.
`define DW_SEL_WIDTH 1
`define DW_SEL_OFFSET 2

`endif

/* common/dw_pkg.sv */
// --------------------
// Channel types of the AXI4-Lite downsizer.
// --------------------

`default_nettype none

`include "dw_defines.svh"

package dw_pkg;

  // AXI response code. OKAY is zero, so an OR merge keeps the worst code.
  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY = 2'b00;

  // Selects one master-width lane of the wide word.
  typedef logic [`DW_SEL_WIDTH-1:0] sel_t;

  // Address request, used for AW and AR on both ports.
  typedef struct packed {
    logic [`DW_ADDR_WIDTH-1:0] addr;
    logic [2:0]                prot;
  } addr_chan_t;

  // Write data beats of the slave and the master port.
  typedef struct packed {
    logic [`DW_SLV_DATA_WIDTH-1:0] data;
    logic [`DW_SLV_STRB_WIDTH-1:0] strb;
  } slv_w_t;

  typedef struct packed {
    logic [`DW_MST_DATA_WIDTH-1:0] data;
    logic [`DW_MST_STRB_WIDTH-1:0] strb;
  } mst_w_t;

  // Write response, identical on both ports.
  typedef struct packed {
    resp_t resp;
  } b_t;

  // Read data beats of the master and the slave port.
  typedef struct packed {
    logic [`DW_MST_DATA_WIDTH-1:0] data;
    resp_t                         resp;
  } mst_r_t;

  typedef struct packed {
    logic [`DW_SLV_DATA_WIDTH-1:0] data;
    resp_t                         resp;
  } slv_r_t;

  // The wide data word, seen either whole or as master-width lanes.
  // Lane 0 holds the least significant bits.
  typedef union packed {
    logic [`DW_SLV_DATA_WIDTH-1:0]                            word;
    logic [`DW_DOWNSIZE_FACTOR-1:0][`DW_MST_DATA_WIDTH-1:0] lane;
  } wide_data_u;

endpackage

`default_nettype wire

/* downsizer/dw_addr_split.sv */
// --------------------
// Address splitter of the downsizer.
// Issues one aligned master request per lane of a wide AW or AR.
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "dw_defines.svh"

module dw_addr_split (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               req_valid_i,
  output logic                    req_ready_o,
  input  wire dw_pkg::addr_chan_t req_i,
  output logic                    mst_valid_o,
  input  wire logic               mst_ready_i,
  output dw_pkg::addr_chan_t      mst_o
);

  import dw_pkg::*;

  // Lane counter, it names the lane of the current master request.
  sel_t sel_q;
  logic last_lane;
  logic mst_hs;

  assign last_lane = (sel_q == sel_t'(`DW_DOWNSIZE_FACTOR - 1));
  assign mst_hs    = mst_valid_o & mst_ready_i;

  // The request stays in the spill register until its last lane is taken.
  assign mst_valid_o = req_valid_i;
  assign req_ready_o = mst_ready_i & last_lane;

  // The selector field takes the lane number and the byte offset is cleared.
  always_comb begin
    mst_o                                       = req_i;
    mst_o.addr[`DW_SEL_OFFSET +: `DW_SEL_WIDTH] = sel_q;
    mst_o.addr[`DW_SEL_OFFSET-1:0]              = '0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
    end else if (mst_hs) begin
      sel_q <= last_lane ? '0 : sel_t'(sel_q + 1'b1);
    end
  end

endmodule

`default_nettype wire

/* downsizer/dw_bresp_merge.sv */
// --------------------
// Write response merger of the downsizer.
// Folds the master B beats of one split write into one slave B.
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "dw_defines.svh"

module dw_bresp_merge (
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire logic       mst_b_valid_i,
  output logic            mst_b_ready_o,
  input  wire dw_pkg::b_t mst_b_i,
  output logic            slv_b_valid_o,
  input  wire logic       slv_b_ready_i,
  output dw_pkg::b_t      slv_b_o
);

  import dw_pkg::*;

  // Count of B beats already taken and the OR of their responses.
  sel_t  cnt_q;
  resp_t resp_q;
  logic  last_lane;
  logic  mst_hs;

  assign last_lane = (cnt_q == sel_t'(`DW_DOWNSIZE_FACTOR - 1));
  assign mst_hs    = mst_b_valid_i & mst_b_ready_o;

  // Early beats are absorbed here.
  // The last beat is forwarded, so slave back-pressure reaches the master directly.
  assign mst_b_ready_o = last_lane ? slv_b_ready_i : 1'b1;
  assign slv_b_valid_o = mst_b_valid_i & last_lane;
  assign slv_b_o.resp  = resp_q | mst_b_i.resp;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      resp_q <= RESP_OKAY;
    end else if (mst_hs) begin
      cnt_q  <= last_lane ? '0 : sel_t'(cnt_q + 1'b1);
      // The merged value starts fresh for the next write.
      resp_q <= last_lane ? RESP_OKAY : (resp_q | mst_b_i.resp);
    end
  end

endmodule

`default_nettype wire

/* downsizer/dw_rdata_gather.sv */
// --------------------
// Read data gatherer of the downsizer.
// Packs the master R beats of one split read into one wide slave R.
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "dw_defines.svh"

module dw_rdata_gather (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire logic           mst_r_valid_i,
  output logic                mst_r_ready_o,
  input  wire dw_pkg::mst_r_t mst_r_i,
  output logic                slv_r_valid_o,
  input  wire logic           slv_r_ready_i,
  output dw_pkg::slv_r_t      slv_r_o
);

  import dw_pkg::*;

  // Beat counter over the lanes of the current read.
  sel_t       cnt_q;
  logic       last_lane;
  logic       mst_hs;
  // One register per lane except the top one, which is taken from the master port.
  mst_r_t [`DW_DOWNSIZE_FACTOR-2:0] lane_q;
  wide_data_u gather;
  resp_t      resp_merged;

  assign last_lane = (cnt_q == sel_t'(`DW_DOWNSIZE_FACTOR - 1));
  assign mst_hs    = mst_r_valid_i & mst_r_ready_o;

  // The last beat is only accepted when the slave can take the wide word.
  assign mst_r_ready_o = last_lane ? slv_r_ready_i : 1'b1;
  assign slv_r_valid_o = mst_r_valid_i & last_lane;

  // Stored lanes fill the low part of the word, and the live beat fills the top lane.
  // The response is the OR over every lane of the read.
  always_comb begin
    gather.lane[`DW_DOWNSIZE_FACTOR-1] = mst_r_i.data;
    resp_merged                        = mst_r_i.resp;
    for (int i = 0; i < `DW_DOWNSIZE_FACTOR - 1; i++) begin
      gather.lane[i] = lane_q[i].data;
      resp_merged    = resp_merged | lane_q[i].resp;
    end
    slv_r_o.data = gather.word;
    slv_r_o.resp = resp_merged;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (mst_hs) begin
      cnt_q <= last_lane ? '0 : sel_t'(cnt_q + 1'b1);
    end
  end

  // Each early beat lands in the register of its own lane.
  // Every lane is rewritten before the last beat of the next read.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `DW_DOWNSIZE_FACTOR - 1; i++) begin
      if (mst_hs && (cnt_q == sel_t'(i))) begin
        lane_q[i] <= mst_r_i;
      end
    end
  end

endmodule

`default_nettype wire

/* downsizer/dw_wdata_split.sv */
// --------------------
// Write data splitter of the downsizer.
// Sends one wide W beat as a series of master-width beats.
// --------------------

`timescale 1ns/1ns
`default_nettype none

`include "dw_defines.svh"

module dw_wdata_split (
  input  wire logic           clk_i,
  input  wire logic           rst_n_i,
  input  wire logic           w_valid_i,
  output logic                w_ready_o,
  input  wire dw_pkg::slv_w_t w_i,
  output logic                mst_w_valid_o,
  input  wire logic           mst_w_ready_i,
  output dw_pkg::mst_w_t      mst_w_o
);

  import dw_pkg::*;

  // This counter runs apart from the AW one, as the two channels are decoupled.
  sel_t       sel_q;
  logic       last_lane;
  logic       mst_hs;
  wide_data_u data_view;

  assign last_lane = (sel_q == sel_t'(`DW_DOWNSIZE_FACTOR - 1));
  assign mst_hs    = mst_w_valid_o & mst_w_ready_i;

  assign mst_w_valid_o = w_valid_i;
  assign w_ready_o     = mst_w_ready_i & last_lane;

  // Lane k of data goes out with strobe lane k.
  // A lane with an all-zero strobe is still sent, so the beat count stays fixed.
  always_comb begin
    data_view.word = w_i.data;
    mst_w_o.data   = data_view.lane[sel_q];
    mst_w_o.strb   = w_i.strb[sel_q * `DW_MST_STRB_WIDTH +: `DW_MST_STRB_WIDTH];
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= '0;
    end else if (mst_hs) begin
      sel_q <= last_lane ? '0 : sel_t'(sel_q + 1'b1);
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+common
common/dw_pkg.sv
source/axi_lite_spill.sv
downsizer/dw_addr_split.sv
downsizer/dw_wdata_split.sv
downsizer/dw_bresp_merge.sv
downsizer/dw_rdata_gather.sv
source/axi_lite_dw_downsizer.sv
bench/dw_downsizer_sva.sv
bench/tb_dw_downsizer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the downsizer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_dw_downsizer \
  -o sim_dw_downsizer

./obj_dir/sim_dw_downsizer | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* source/axi_lite_dw_downsizer.sv */
// --------------------
// AXI4-Lite data-width downsizer, 64-bit slave port to 32-bit master port.
// Requests are buffered, split per lane, and responses are merged back.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module axi_lite_dw_downsizer (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  // Slave port, driven by the wide manager.
  input  wire logic               slv_aw_valid_i,
  output logic                    slv_aw_ready_o,
  input  wire dw_pkg::addr_chan_t slv_aw_i,
  input  wire logic               slv_w_valid_i,
  output logic                    slv_w_ready_o,
  input  wire dw_pkg::slv_w_t     slv_w_i,
  output logic                    slv_b_valid_o,
  input  wire logic               slv_b_ready_i,
  output dw_pkg::b_t              slv_b_o,
  input  wire logic               slv_ar_valid_i,
  output logic                    slv_ar_ready_o,
  input  wire dw_pkg::addr_chan_t slv_ar_i,
  output logic                    slv_r_valid_o,
  input  wire logic               slv_r_ready_i,
  output dw_pkg::slv_r_t          slv_r_o,
  // Master port, toward the narrow subordinate.
  output logic                    mst_aw_valid_o,
  input  wire logic               mst_aw_ready_i,
  output dw_pkg::addr_chan_t      mst_aw_o,
  output logic                    mst_w_valid_o,
  input  wire logic               mst_w_ready_i,
  output dw_pkg::mst_w_t          mst_w_o,
  input  wire logic               mst_b_valid_i,
  output logic                    mst_b_ready_o,
  input  wire dw_pkg::b_t         mst_b_i,
  output logic                    mst_ar_valid_o,
  input  wire logic               mst_ar_ready_i,
  output dw_pkg::addr_chan_t      mst_ar_o,
  input  wire logic               mst_r_valid_i,
  output logic                    mst_r_ready_o,
  input  wire dw_pkg::mst_r_t     mst_r_i
);

  import dw_pkg::*;

  // Outputs of the input spill registers.
  addr_chan_t aw_spill;
  logic       aw_spill_valid;
  logic       aw_spill_ready;
  slv_w_t     w_spill;
  logic       w_spill_valid;
  logic       w_spill_ready;
  addr_chan_t ar_spill;
  logic       ar_spill_valid;
  logic       ar_spill_ready;

  // The three request channels enter through spill registers.
  axi_lite_spill #(
    .WIDTH ( $bits(addr_chan_t) )
  ) i_spill_aw (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( slv_aw_valid_i ),
    .ready_o ( slv_aw_ready_o ),
    .data_i  ( slv_aw_i       ),
    .valid_o ( aw_spill_valid ),
    .ready_i ( aw_spill_ready ),
    .data_o  ( aw_spill       )
  );

  axi_lite_spill #(
    .WIDTH ( $bits(slv_w_t) )
  ) i_spill_w (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .valid_i ( slv_w_valid_i ),
    .ready_o ( slv_w_ready_o ),
    .data_i  ( slv_w_i       ),
    .valid_o ( w_spill_valid ),
    .ready_i ( w_spill_ready ),
    .data_o  ( w_spill       )
  );

  axi_lite_spill #(
    .WIDTH ( $bits(addr_chan_t) )
  ) i_spill_ar (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( slv_ar_valid_i ),
    .ready_o ( slv_ar_ready_o ),
    .data_i  ( slv_ar_i       ),
    .valid_o ( ar_spill_valid ),
    .ready_i ( ar_spill_ready ),
    .data_o  ( ar_spill       )
  );

  // Write address and data are split on their own, each with its own lane counter.
  dw_addr_split i_aw_split (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .req_valid_i ( aw_spill_valid ),
    .req_ready_o ( aw_spill_ready ),
    .req_i       ( aw_spill       ),
    .mst_valid_o ( mst_aw_valid_o ),
    .mst_ready_i ( mst_aw_ready_i ),
    .mst_o       ( mst_aw_o       )
  );

  dw_wdata_split i_w_split (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .w_valid_i     ( w_spill_valid ),
    .w_ready_o     ( w_spill_ready ),
    .w_i           ( w_spill       ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i ),
    .mst_w_o       ( mst_w_o       )
  );

  dw_addr_split i_ar_split (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .req_valid_i ( ar_spill_valid ),
    .req_ready_o ( ar_spill_ready ),
    .req_i       ( ar_spill       ),
    .mst_valid_o ( mst_ar_valid_o ),
    .mst_ready_i ( mst_ar_ready_i ),
    .mst_o       ( mst_ar_o       )
  );

  // Responses come straight from the master port and are merged toward the slave.
  dw_bresp_merge i_b_merge (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .mst_b_i       ( mst_b_i       ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i ),
    .slv_b_o       ( slv_b_o       )
  );

  dw_rdata_gather i_r_gather (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .mst_r_i       ( mst_r_i       ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .slv_r_o       ( slv_r_o       )
  );

endmodule

`default_nettype wire

/* source/axi_lite_spill.sv */
// --------------------
// Two-entry spill register for one valid/ready channel.
// Both the forward and the backward path are registered.
// --------------------

`timescale 1ns/1ns
`default_nettype none

module axi_lite_spill #(
  parameter int unsigned WIDTH = $bits(dw_pkg::addr_chan_t)
) (
  input  wire logic             clk_i,
  input  wire logic             rst_n_i,
  input  wire logic             valid_i,
  output logic                  ready_o,
  input  wire logic [WIDTH-1:0] data_i,
  output logic                  valid_o,
  input  wire logic             ready_i,
  output logic      [WIDTH-1:0] data_o
);

  // Storage slots and their fill flags.
  logic [1:0][WIDTH-1:0] slot_q;
  logic [1:0]            full_q;
  logic [1:0]            full_d;
  // The write pointer names the next free slot, the read pointer the oldest entry.
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic                  push;
  logic                  pop;

  // Ready drops only when both slots hold data.
  assign ready_o = ~(full_q[0] & full_q[1]);
  assign valid_o = full_q[rd_ptr_q];
  assign data_o  = slot_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // A push and a pop in one cycle always touch different slots.
  always_comb begin
    full_d = full_q;
    if (pop) begin
      full_d[rd_ptr_q] = 1'b0;
    end
    if (push) begin
      full_d[wr_ptr_q] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q   <= 2'b00;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      full_q <= full_d;
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  // The payload is only captured into a free slot.
  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire
